//--- src.f
+incdir+logic
logic/core_pkg.sv
logic/byte_ram.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/host_port.sv
logic/pipelined_processor.sv
dv/tb_clk.sv
dv/core_asserts.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_top -f src.f -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb +verilator+error+limit+100)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
exit 1

//--- dv/tb_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_top;

    localparam int RESET_CYCLES    = 10;
    localparam int RUN_CYCLES      = 40;   // poll budget per row
    localparam int ROW_LOAD_CYCLES = 20;   // reset, preloads, program, start, readback
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam core_pkg::word_t ECALL    = 32'h0000_0073;
    localparam core_pkg::word_t SENTINEL = 32'hdead_beef;
    localparam core_pkg::word_t JAL_PC   = 32'd8;   // third program word
    localparam logic [11:0] RESULT_OFS  = 12'h040;
    localparam logic [11:0] SCRATCH_OFS = 12'h044;
    localparam logic [11:0] PRELOAD_OFS = 12'h048;
    localparam core_pkg::host_addr_t IMEM_BASE =
        {`CORE_REGION_IMEM, {(`CORE_HOST_ADDR_BITS-2){1'b0}}};
    localparam core_pkg::host_addr_t DMEM_BASE =
        {`CORE_REGION_DMEM, {(`CORE_HOST_ADDR_BITS-2){1'b0}}};
    localparam core_pkg::host_addr_t CTRL_ADDR =
        {`CORE_REGION_CTRL, {(`CORE_HOST_ADDR_BITS-2){1'b0}}};

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI,   // order used by fill_table
        OP_CHAIN, OP_BEQ, OP_BNE, OP_JAL, OP_LW_SW, OP_LW_PRE, OP_HALT
    } test_op_t;

    typedef struct packed {
        test_op_t        op;
        core_pkg::word_t a;
        core_pkg::word_t b;
        core_pkg::word_t expected;
    } row_t;

    logic                 clk_in;
    logic                 reset;
    core_pkg::word_t      bram_din;
    core_pkg::host_addr_t bram_addr;
    core_pkg::byte_en_t   bram_wr_en;
    core_pkg::word_t      bram_dout;

    row_t            rows [$];
    core_pkg::word_t prog [$];
    core_pkg::word_t lcg_state = 32'd11216;
    int              errors = 0;
    int              cycles = 0;
    int              cycle_limit = 0;

    tb_clk #(.PERIOD_NS(40)) clk_gen (.clk_in(clk_in));

    pipelined_processor i_dut (
        .clk_in     (clk_in),
        .reset      (reset),
        .bram_din   (bram_din),
        .bram_addr  (bram_addr),
        .bram_wr_en (bram_wr_en),
        .bram_dout  (bram_dout)
    );

    // 12-bit signed operand from the upper LCG bits
    function automatic core_pkg::word_t next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {{20{lcg_state[27]}}, lcg_state[27:16]};
    endfunction

    function automatic core_pkg::word_t r_type(input logic [6:0] funct7,
                                               input core_pkg::reg_idx_t rs2,
                                               input core_pkg::reg_idx_t rs1,
                                               input logic [2:0] funct3,
                                               input core_pkg::reg_idx_t rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word_t i_type(input logic [11:0] imm,
                                               input core_pkg::reg_idx_t rs1,
                                               input logic [2:0] funct3,
                                               input core_pkg::reg_idx_t rd,
                                               input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic core_pkg::word_t s_type(input logic [11:0] imm,
                                               input core_pkg::reg_idx_t rs2,
                                               input core_pkg::reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word_t b_type(input logic [12:0] imm,
                                               input core_pkg::reg_idx_t rs2,
                                               input core_pkg::reg_idx_t rs1,
                                               input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word_t j_type(input logic [20:0] imm,
                                               input core_pkg::reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // result word the program leaves at RESULT_OFS
    function automatic core_pkg::word_t expected_of(input test_op_t op,
                                                    input core_pkg::word_t a,
                                                    input core_pkg::word_t b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:    return a - b;
            OP_AND:    return a & b;
            OP_OR:     return a | b;
            OP_XOR:    return a ^ b;
            OP_CHAIN:  return a + (a + b);
            OP_BEQ:    return (a == b) ? 32'd9 : 32'd15;   // 1 + 8 when skipped
            OP_BNE:    return (a != b) ? 32'd9 : 32'd15;
            OP_JAL:    return JAL_PC + 32'd4;
            OP_LW_SW:  return a;
            OP_LW_PRE: return b + a;
            default:   return SENTINEL;                   // store after ECALL never lands
        endcase
    endfunction

    function automatic void add_row(input test_op_t op, input core_pkg::word_t a,
                                    input core_pkg::word_t b);
        row_t r;
        r.op       = op;
        r.a        = a;
        r.b        = b;
        r.expected = expected_of(op, a, b);
        rows.push_back(r);
    endfunction

    function automatic void fill_table();
        core_pkg::word_t a;
        core_pkg::word_t b;
        for (int k = 0; k < 6; k++) begin
            repeat (2) begin
                a = next_rand();
                b = next_rand();
                add_row(test_op_t'(k[3:0]), a, b);
            end
        end
        add_row(OP_SUB, 32'hffff_f800, 32'h0000_07ff);   // most negative minus most positive
        a = next_rand();
        b = next_rand();
        add_row(OP_CHAIN, a, b);
        add_row(OP_BEQ, 32'd5, 32'd5);
        add_row(OP_BEQ, 32'd5, 32'hffff_fffd);
        add_row(OP_BNE, 32'd7, 32'd7);
        add_row(OP_BNE, 32'hffff_fffe, 32'd9);
        add_row(OP_JAL, next_rand(), 32'd3);
        add_row(OP_LW_SW, next_rand(), 32'd0);
        add_row(OP_LW_PRE, next_rand(), 32'h1234_5678);
        add_row(OP_HALT, next_rand(), 32'd0);
    endfunction

    // every program leaves its answer in x3
    function automatic void build_program(input row_t r);
        logic [2:0] f3;
        logic [6:0] f7;
        prog.delete();
        case (r.op)
            OP_ADDI: begin
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(i_type(r.b[11:0], 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
            end
            OP_CHAIN: begin
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(i_type(r.b[11:0], 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
                prog.push_back(r_type(7'b0000000, 5'd1, 5'd2, 3'b000, 5'd3));
            end
            OP_BEQ, OP_BNE: begin
                f3 = (r.op == OP_BNE) ? 3'b001 : 3'b000;
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(i_type(r.b[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
                prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(b_type(13'd12, 5'd2, 5'd1, f3));   // skips the next two
                prog.push_back(i_type(12'd2, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(i_type(12'd4, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(i_type(12'd8, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
            end
            OP_JAL: begin
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(i_type(r.b[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
                prog.push_back(j_type(21'd12, 5'd3));             // at JAL_PC
                prog.push_back(i_type(12'hfff, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(i_type(12'hfff, 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
            end
            OP_LW_SW: begin
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(s_type(SCRATCH_OFS, 5'd1, 5'd0));
                prog.push_back(i_type(SCRATCH_OFS, 5'd0, 3'b010, 5'd3, OPC_LOAD));
            end
            OP_LW_PRE: begin
                prog.push_back(i_type(PRELOAD_OFS, 5'd0, 3'b010, 5'd1, OPC_LOAD));
                prog.push_back(i_type(r.a[11:0], 5'd1, 3'b000, 5'd3, OPC_OP_IMM));
            end
            OP_HALT: begin
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd3, OPC_OP_IMM));
                prog.push_back(ECALL);
            end
            default: begin
                f7 = (r.op == OP_SUB) ? 7'b0100000 : 7'b0000000;
                case (r.op)
                    OP_AND:  f3 = 3'b111;
                    OP_OR:   f3 = 3'b110;
                    OP_XOR:  f3 = 3'b100;
                    default: f3 = 3'b000;
                endcase
                prog.push_back(i_type(r.a[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
                prog.push_back(i_type(r.b[11:0], 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
                prog.push_back(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
            end
        endcase
        prog.push_back(s_type(RESULT_OFS, 5'd3, 5'd0));
        prog.push_back(ECALL);
    endfunction

    // all host tasks start and end 5 ns after a rising edge
    task automatic write_word(input core_pkg::host_addr_t addr, input core_pkg::word_t data);
        bram_addr  = addr;
        bram_din   = data;
        bram_wr_en = 4'hf;
        @(posedge clk_in);
        #5;
        bram_wr_en = '0;
    endtask

    task automatic read_word(input core_pkg::host_addr_t addr, output core_pkg::word_t data);
        bram_addr  = addr;
        bram_wr_en = '0;
        @(posedge clk_in);
        #5;
        data = bram_dout;   // registered readback, valid one edge later
    endtask

    task automatic apply_reset(input int n);
        reset = 1'b1;
        repeat (n) @(posedge clk_in);
        #5;
        reset = 1'b0;
    endtask

    task automatic run_row(input int idx);
        row_t            r;
        test_op_t        op;
        core_pkg::word_t ctrl;
        core_pkg::word_t got;
        int              polls;
        bit              ok;
        r  = rows[idx];
        op = r.op;
        ok = 1'b1;
        apply_reset(2);   // pc back to zero, register file cleared
        write_word(DMEM_BASE | core_pkg::host_addr_t'(RESULT_OFS), SENTINEL);
        if (op == OP_LW_PRE) begin
            write_word(DMEM_BASE | core_pkg::host_addr_t'(PRELOAD_OFS), r.b);
        end
        build_program(r);
        foreach (prog[i]) begin
            write_word(IMEM_BASE | core_pkg::host_addr_t'(4 * i), prog[i]);
        end
        write_word(CTRL_ADDR, 32'd1);
        polls = 0;
        ctrl  = '0;
        while (!ctrl[1] && polls < RUN_CYCLES) begin
            read_word(CTRL_ADDR, ctrl);
            polls++;
        end
        if (!ctrl[1]) begin
            $display("row %0d: core did not report halted within %0d polls", idx, RUN_CYCLES);
            ok = 1'b0;
        end else if (ctrl[0]) begin
            $display("ERROR at %0t ns: bram_dout[0] (run) = 1, expected 0", $time);
            ok = 1'b0;
        end
        read_word(DMEM_BASE | core_pkg::host_addr_t'(RESULT_OFS), got);
        if (got !== r.expected) begin
            $display("ERROR at %0t ns: bram_dout (result word) = 0x%h, expected 0x%h",
                     $time, got, r.expected);
            ok = 1'b0;
        end
        if (ok) begin
            $display("row %0d %s a=0x%h b=0x%h: ok", idx, op.name(), r.a, r.b);
        end else begin
            errors++;
            $display("row %0d %s a=0x%h b=0x%h: failed", idx, op.name(), r.a, r.b);
        end
    endtask

    always @(posedge clk_in) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        reset      = 1'b1;
        bram_din   = '0;
        bram_addr  = '0;
        bram_wr_en = '0;
        fill_table();
        cycle_limit = RESET_CYCLES + rows.size() * (RUN_CYCLES + ROW_LOAD_CYCLES);
        repeat (RESET_CYCLES) @(posedge clk_in);
        #5;
        reset = 1'b0;
        foreach (rows[i]) begin
            run_row(i);
        end
        $display("rows: %0d, failed: %0d, assertion failures: %0d",
                 rows.size(), errors, i_dut.u_asserts.assert_fails);
        if (errors == 0 && i_dut.u_asserts.assert_fails == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- dv/core_asserts.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_asserts (
    input logic                 clk_in,
    input logic                 reset,
    input logic                 run,
    input logic                 halt,
    input core_pkg::id_ex_t     id_ex,
    input core_pkg::word_t      x0_val,
    input core_pkg::redirect_t  redirect,
    input core_pkg::host_addr_t bram_addr,
    input core_pkg::byte_en_t   bram_wr_en
);

    int   assert_fails = 0;
    logic ctrl_wr;

    assign ctrl_wr = (bram_addr[`CORE_HOST_ADDR_BITS-1 -: 2] == `CORE_REGION_CTRL)
                     && bram_wr_en[0];

    // the halt pulse stops the pipeline at its own edge
    halt_stops_run: assert property (@(posedge clk_in) disable iff (reset) halt |=> !run)
        else begin
            $error("run still high after halt");
            assert_fails++;
        end

    redirect_squashes: assert property (@(posedge clk_in) disable iff (reset)
        redirect.valid |=> !id_ex.valid)   // wrong-path instruction in decode is dropped
        else begin
            $error("instruction after a redirect reached execute");
            assert_fails++;
        end

    x0_stays_zero: assert property (@(posedge clk_in) disable iff (reset)
        x0_val == '0)
        else begin
            $error("register x0 was written");
            assert_fails++;
        end

    // run only rises through the control register
    run_needs_ctrl: assert property (@(posedge clk_in) disable iff (reset)
        (!run && !ctrl_wr) |=> !run)
        else begin
            $error("run rose without a host control write");
            assert_fails++;
        end

endmodule

bind pipelined_processor core_asserts u_asserts (
    .clk_in     (clk_in),
    .reset      (reset),
    .run        (run),
    .halt       (halt),
    .id_ex      (id_ex),
    .x0_val     (u_decode.regs[0]),
    .redirect   (redirect),
    .bram_addr  (bram_addr),
    .bram_wr_en (bram_wr_en)
);

//--- dv/tb_clk.sv
`timescale 1ns/1ps

module tb_clk #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_in
);

    // free-running, first rising edge at half a period
    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2) clk_in = ~clk_in;
    end

endmodule

//--- logic/pipelined_processor.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module pipelined_processor (
    input  logic                 clk_in,
    input  logic                 reset,
    input  core_pkg::word_t      bram_din,
    input  core_pkg::host_addr_t bram_addr,
    input  core_pkg::byte_en_t   bram_wr_en,
    output core_pkg::word_t      bram_dout
);

    core_pkg::byte_en_t  imem_host_wr, dmem_host_wr;
    core_pkg::word_t     imem_rd, dmem_rd;
    logic                run, halt;
    core_pkg::redirect_t redirect;
    core_pkg::if_id_t    if_id;
    core_pkg::id_ex_t    id_ex;
    core_pkg::ex_wb_t    ex_wb;

    host_port u_host (
        .clk_in       (clk_in),
        .reset        (reset),
        .bram_din     (bram_din),
        .bram_addr    (bram_addr),
        .bram_wr_en   (bram_wr_en),
        .bram_dout    (bram_dout),
        .halt         (halt),
        .imem_rd      (imem_rd),
        .dmem_rd      (dmem_rd),
        .imem_host_wr (imem_host_wr),
        .dmem_host_wr (dmem_host_wr),
        .run          (run)
    );

    fetch_stage u_fetch (
        .clk_in         (clk_in),
        .reset          (reset),
        .run            (run),
        .redirect       (redirect),
        .host_word_addr (bram_addr[$clog2(`CORE_IMEM_WORDS)+1:2]),
        .host_wdata     (bram_din),
        .host_wr        (imem_host_wr),
        .host_rdata     (imem_rd),
        .if_id          (if_id)
    );

    decode_stage u_decode (
        .clk_in   (clk_in),
        .reset    (reset),
        .run      (run),
        .if_id    (if_id),
        .redirect (redirect),
        .ex_wb    (ex_wb),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk_in         (clk_in),
        .reset          (reset),
        .run            (run),
        .id_ex          (id_ex),
        .host_word_addr (bram_addr[$clog2(`CORE_DMEM_WORDS)+1:2]),
        .host_wdata     (bram_din),
        .host_wr        (dmem_host_wr),
        .host_rdata     (dmem_rd),
        .ex_wb          (ex_wb),
        .redirect       (redirect),
        .halt           (halt)
    );

endmodule

//--- logic/host_port.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module host_port (
    input  logic                 clk_in,
    input  logic                 reset,
    input  core_pkg::word_t      bram_din,
    input  core_pkg::host_addr_t bram_addr,
    input  core_pkg::byte_en_t   bram_wr_en,
    output core_pkg::word_t      bram_dout,
    input  logic                 halt,
    input  core_pkg::word_t      imem_rd,
    input  core_pkg::word_t      dmem_rd,
    output core_pkg::byte_en_t   imem_host_wr,
    output core_pkg::byte_en_t   dmem_host_wr,
    output logic                 run
);

    logic [1:0] region;
    logic [1:0] region_q;   // follows the synchronous memory read
    logic       halted;
    logic       ctrl_wr;

    assign region       = bram_addr[`CORE_HOST_ADDR_BITS-1 -: 2];
    assign imem_host_wr = (region == `CORE_REGION_IMEM) ? bram_wr_en : '0;
    assign dmem_host_wr = (region == `CORE_REGION_DMEM) ? bram_wr_en : '0;
    assign ctrl_wr      = (region == `CORE_REGION_CTRL) && bram_wr_en[0];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            run    <= 1'b0;
            halted <= 1'b0;
        end else if (ctrl_wr) begin
            run    <= bram_din[0];
            halted <= halted && !bram_din[0];   // starting clears halted
        end else if (halt) begin
            run    <= 1'b0;
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            region_q <= `CORE_REGION_IMEM;
        end else begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            `CORE_REGION_IMEM: bram_dout = imem_rd;
            `CORE_REGION_DMEM: bram_dout = dmem_rd;
            `CORE_REGION_CTRL: bram_dout = {30'd0, halted, run};
            default:           bram_dout = '0;
        endcase
    end

endmodule

//--- logic/execute_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                                 clk_in,
    input  logic                                 reset,
    input  logic                                 run,
    input  core_pkg::id_ex_t                     id_ex,
    input  logic [$clog2(`CORE_DMEM_WORDS)-1:0]  host_word_addr,
    input  core_pkg::word_t                      host_wdata,
    input  core_pkg::byte_en_t                   host_wr,
    output core_pkg::word_t                      host_rdata,
    output core_pkg::ex_wb_t                     ex_wb,
    output core_pkg::redirect_t                  redirect,
    output logic                                 halt
);

    localparam int AW = $clog2(`CORE_DMEM_WORDS);

    logic            live;
    logic            taken;
    logic            halted_seen;
    core_pkg::word_t op_b;
    core_pkg::word_t alu_out;
    core_pkg::word_t mem_rdata;

    assign live = id_ex.valid && run;
    assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_val;

    always_comb begin
        case (id_ex.alu_op)
            core_pkg::ALU_ADD: alu_out = id_ex.rs1_val + op_b;
            core_pkg::ALU_SUB: alu_out = id_ex.rs1_val - op_b;
            core_pkg::ALU_AND: alu_out = id_ex.rs1_val & op_b;
            core_pkg::ALU_OR:  alu_out = id_ex.rs1_val | op_b;
            core_pkg::ALU_XOR: alu_out = id_ex.rs1_val ^ op_b;
            default:           alu_out = op_b;
        endcase
    end

    // BEQ / BNE share one comparator
    assign taken = id_ex.branch && ((id_ex.rs1_val == id_ex.rs2_val) != id_ex.branch_ne);

    assign redirect.valid  = live && (taken || id_ex.jump);
    assign redirect.target = id_ex.pc + id_ex.imm;

    byte_ram #(.DEPTH(`CORE_DMEM_WORDS)) dmem (
        .clk_in         (clk_in),
        .host_word_addr (host_word_addr),
        .host_wdata     (host_wdata),
        .host_wr        (host_wr),
        .host_rdata     (host_rdata),
        .core_word_addr (alu_out[AW+1:2]),   // word aligned only
        .core_wdata     (id_ex.rs2_val),
        .core_wr        ({4{live && id_ex.mem_write}}),
        .core_rdata     (mem_rdata)
    );

    always_comb begin
        ex_wb.reg_write = live && id_ex.reg_write && (id_ex.rd != '0);
        ex_wb.rd        = id_ex.rd;
        case (id_ex.wb_src)
            core_pkg::WB_MEM:  ex_wb.data = id_ex.mem_read ? mem_rdata : '0;
            core_pkg::WB_LINK: ex_wb.data = id_ex.pc + 32'd4;
            default:           ex_wb.data = alu_out;
        endcase
    end

    // one pulse per ECALL, even if the host leaves run high for an extra cycle
    always_ff @(posedge clk_in) begin
        if (reset) begin
            halted_seen <= 1'b0;
        end else begin
            halted_seen <= halt;
        end
    end

    assign halt = live && id_ex.halt && !halted_seen;

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                clk_in,
    input  logic                reset,
    input  logic                run,
    input  core_pkg::if_id_t    if_id,
    input  core_pkg::redirect_t redirect,
    input  core_pkg::ex_wb_t    ex_wb,
    output core_pkg::id_ex_t    id_ex
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    core_pkg::word_t regs [32];
    core_pkg::word_t instr;
    core_pkg::reg_idx_t rs1, rs2;
    core_pkg::word_t rs1_val, rs2_val;
    core_pkg::id_ex_t d;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ex_wb.reg_write) begin
            regs[ex_wb.rd] <= ex_wb.data;
        end
    end

    // x0 reads zero, then the instruction in execute takes precedence
    always_comb begin
        rs1_val = (rs1 == '0) ? '0 : regs[rs1];
        rs2_val = (rs2 == '0) ? '0 : regs[rs2];
        if (ex_wb.reg_write && ex_wb.rd == rs1) rs1_val = ex_wb.data;
        if (ex_wb.reg_write && ex_wb.rd == rs2) rs2_val = ex_wb.data;
    end

    always_comb begin
        d         = '0;           // anything unsupported is a no-op
        d.alu_op  = core_pkg::ALU_PASS_B;
        d.wb_src  = core_pkg::WB_ALU;
        d.valid   = if_id.valid && !redirect.valid;
        d.pc      = if_id.pc;
        d.rs1_val = rs1_val;
        d.rs2_val = rs2_val;
        d.rd      = instr[11:7];
        case (opcode)
            OPC_OP: begin
                d.reg_write = 1'b1;
                case (funct3)
                    3'b000:  d.alu_op = funct7[5] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                    3'b111:  d.alu_op = core_pkg::ALU_AND;
                    3'b110:  d.alu_op = core_pkg::ALU_OR;
                    3'b100:  d.alu_op = core_pkg::ALU_XOR;
                    default: d.reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_LOAD: begin     // ADDI and LW share the I-immediate
                d.imm       = {{20{instr[31]}}, instr[31:20]};
                d.alu_op    = core_pkg::ALU_ADD;
                d.use_imm   = 1'b1;
                d.mem_read  = (opcode == OPC_LOAD) && (funct3 == 3'b010);
                d.reg_write = (funct3 == ((opcode == OPC_LOAD) ? 3'b010 : 3'b000));
                d.wb_src    = d.mem_read ? core_pkg::WB_MEM : core_pkg::WB_ALU;
            end
            OPC_STORE: begin
                d.imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                d.alu_op    = core_pkg::ALU_ADD;
                d.use_imm   = 1'b1;
                d.mem_write = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                d.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                d.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                d.branch_ne = funct3[0];
            end
            OPC_JAL: begin
                d.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
                d.jump      = 1'b1;
                d.reg_write = 1'b1;
                d.wb_src    = core_pkg::WB_LINK;
            end
            `CORE_OPC_SYSTEM: d.halt = (instr[31:7] == '0);   // ECALL only
            default: ;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            id_ex.valid <= 1'b0;
        end else if (run) begin
            id_ex <= d;
        end
    end

endmodule

//--- logic/fetch_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_stage (
    input  logic                                 clk_in,
    input  logic                                 reset,
    input  logic                                 run,
    input  core_pkg::redirect_t                  redirect,
    input  logic [$clog2(`CORE_IMEM_WORDS)-1:0]  host_word_addr,
    input  core_pkg::word_t                      host_wdata,
    input  core_pkg::byte_en_t                   host_wr,
    output core_pkg::word_t                      host_rdata,
    output core_pkg::if_id_t                     if_id
);

    localparam int AW = $clog2(`CORE_IMEM_WORDS);

    core_pkg::pc_t   pc;
    core_pkg::word_t instr;

    byte_ram #(.DEPTH(`CORE_IMEM_WORDS)) imem (
        .clk_in         (clk_in),
        .host_word_addr (host_word_addr),
        .host_wdata     (host_wdata),
        .host_wr        (host_wr),
        .host_rdata     (host_rdata),
        .core_word_addr (pc[AW+1:2]),
        .core_wdata     ('0),         // core never writes program memory
        .core_wr        ('0),
        .core_rdata     (instr)
    );

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pc <= '0;
        end else if (run) begin
            pc <= redirect.valid ? redirect.target : pc + 32'd4;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            if_id.valid <= 1'b0;
        end else if (run) begin
            if_id.valid <= !redirect.valid;  // squash the wrong-path fetch
            if_id.pc    <= pc;
            if_id.instr <= instr;
        end
    end

endmodule

//--- logic/byte_ram.sv
`timescale 1ns/1ps

module byte_ram #(
    parameter int DEPTH = 256
) (
    input  logic                       clk_in,
    input  logic [$clog2(DEPTH)-1:0]   host_word_addr,
    input  core_pkg::word_t            host_wdata,
    input  core_pkg::byte_en_t         host_wr,
    output core_pkg::word_t            host_rdata,
    input  logic [$clog2(DEPTH)-1:0]   core_word_addr,
    input  core_pkg::word_t            core_wdata,
    input  core_pkg::byte_en_t         core_wr,
    output core_pkg::word_t            core_rdata
);

    core_pkg::word_t mem [DEPTH];

    logic same_addr;

    assign same_addr = (host_word_addr == core_word_addr);

    // each lane written independently from either port
    always_ff @(posedge clk_in) begin
        for (int b = 0; b < 4; b++) begin
            if (host_wr[b]) begin
                mem[host_word_addr][8*b +: 8] <= host_wdata[8*b +: 8];
            end
            if (core_wr[b] && !(host_wr[b] && same_addr)) begin  // host wins a collision
                mem[core_word_addr][8*b +: 8] <= core_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        host_rdata <= mem[host_word_addr];
    end

    // distributed-RAM style read for the pipeline
    assign core_rdata = mem[core_word_addr];

endmodule

//--- logic/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] pc_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [`CORE_HOST_ADDR_BITS-1:0] host_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK    // pc + 4
    } wb_src_t;

    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;
        reg_idx_t rd;
        logic     reg_write;
        alu_op_t  alu_op;
        logic     use_imm;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     branch_ne;  // BNE rather than BEQ
        logic     jump;
        wb_src_t  wb_src;
        logic     halt;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t rd;
        word_t    data;
    } ex_wb_t;

    typedef struct packed {
        logic valid;
        pc_t  target;
    } redirect_t;

endpackage

//--- logic/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// memory depths in 32-bit words
`define CORE_IMEM_WORDS 256
`define CORE_DMEM_WORDS 256

// host byte address, top two bits pick the region
`define CORE_HOST_ADDR_BITS 12

`define CORE_REGION_IMEM 2'b00
`define CORE_REGION_DMEM 2'b01
`define CORE_REGION_CTRL 2'b10

// opcode carrying ECALL
`define CORE_OPC_SYSTEM 7'b1110011

`endif
